// ==== source/mixer_cfg.svh ====
// Widths, depths, pipeline delay and bus address map
// for the audio mixing engine
`ifndef MIXER_CFG_SVH
`define MIXER_CFG_SVH

`define MIX_CODE_W      8       // Program address bits
`define MIX_FRAME_W     4       // Frame, offset and shift bits
`define MIX_CHAN_W      4       // Channel bits
`define MIX_ACC_W       40
`define MIX_OUT_N       16      // Output registers

// Decode to accumulator update, in cycles
`define MIX_PIPE_DLY    3

// Bus word address map
`define MIX_WB_AW       10
`define MIX_COEF_BASE   10'h000
`define MIX_AUDIO_BASE  10'h100
`define MIX_OUT_BASE    10'h200
`define MIX_STATUS_ADDR 10'h210

`endif

// ==== source/mixer_pkg.sv ====
// Data types, opcode encoding and sequencer states of the mixing engine
`include "mixer_cfg.svh"

package mixer_pkg;

    // Instruction: opcode [31:24], offset [23:20], chan [19:16], gain [15:0]
    typedef logic [31:0]                             coef_word_t;
    typedef logic [15:0]                             sample_t;    // Two's complement
    typedef logic [15:0]                             gain_t;      // Unsigned
    typedef logic [`MIX_ACC_W-1:0]                   acc_t;
    typedef logic [31:0]                             product_t;
    typedef logic [`MIX_CODE_W-1:0]                  code_addr_t;
    typedef logic [`MIX_CHAN_W+`MIX_FRAME_W-1:0]     audio_addr_t;
    typedef logic [`MIX_FRAME_W-1:0]                 frame_t;
    typedef logic [`MIX_CHAN_W-1:0]                  chan_t;
    typedef logic [$clog2(`MIX_OUT_N)-1:0]           out_idx_t;

    typedef enum logic [6:0] {
        NOP   = 7'h00,
        MAC   = 7'h40,
        MACN  = 7'h41,
        MACZ  = 7'h42,      // Clear, then add
        MACNZ = 7'h43,      // Clear, then subtract
        SAVE  = 7'h50,
        HALT  = 7'h7F
    } op_t;

    typedef enum logic [1:0] {IDLE, FETCH, DRAIN} seq_state_t;

endpackage

// ==== source/mix_sequencer.sv ====
// Mixing engine sequencer: program counter, instruction latch, decode,
// ring-buffer audio addressing and the control delay lines
`timescale 1ns/10ps
`include "mixer_cfg.svh"

module mix_sequencer (
    input  logic                   ck,
    input  logic                   reset,
    input  logic                   run,
    input  mixer_pkg::frame_t      frame,
    output mixer_pkg::code_addr_t  coef_addr,
    input  mixer_pkg::coef_word_t  coef_data,
    output mixer_pkg::audio_addr_t audio_addr,
    output logic                   acc_en,
    output logic                   acc_clr,
    output logic                   acc_add,
    input  logic                   audio_neg,
    output logic                   shift_en,
    output mixer_pkg::frame_t      shift,
    output mixer_pkg::gain_t       gain,
    output mixer_pkg::out_idx_t    out_idx,
    output logic                   done,
    output logic                   error
);
    import mixer_pkg::*;

    localparam int DLY = `MIX_PIPE_DLY;

    seq_state_t     state;
    coef_word_t     instr;
    op_t            op;
    logic           stop;
    logic           data_v;         // coef_data holds a fetched word
    logic           instr_v;        // instr holds a fetched word
    logic           dec_v;
    logic           dec_mac;
    logic           dec_clr;
    logic           dec_add;
    logic           dec_save;
    logic           dec_halt;
    logic           dec_bad;
    chan_t          chan_f;
    frame_t         ring_pos;
    logic [DLY-1:0] en_sr;
    logic [DLY-1:0] clr_sr;
    logic [DLY-1:0] add_sr;
    logic [DLY-1:0] save_sr;
    logic [DLY:0]   halt_sr;
    frame_t         shift_sr [DLY];
    gain_t          gain_sr  [DLY-1];
    out_idx_t       idx_sr   [DLY+1];

    assign stop = reset || !run;

    always_ff @(posedge ck) begin
        if (stop) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE:    state <= FETCH;
                FETCH:   if (dec_halt) state <= DRAIN;
                DRAIN:   state <= DRAIN;    // Held until run falls
                default: state <= IDLE;
            endcase
        end
    end

    // Address n in cycle n, word back in n+1, decoded in n+2
    always_ff @(posedge ck) begin
        if (stop) begin
            coef_addr <= '0;
            data_v    <= 1'b0;
            instr_v   <= 1'b0;
        end else begin
            if (state != DRAIN && !dec_halt)
                coef_addr <= coef_addr + 1'b1;
            data_v  <= (state != DRAIN) && !dec_halt;
            instr_v <= data_v && !dec_halt;     // Squash words fetched past HALT
        end
    end

    // Ring position wraps inside the channel's 16 samples
    assign chan_f   = coef_data[19:16];
    assign ring_pos = frame + coef_data[23:20];

    // Latched alongside the instruction, so the sample arrives one cycle after decode
    always_ff @(posedge ck) begin
        instr      <= coef_data;
        audio_addr <= {chan_f, ring_pos};
    end

    assign op    = op_t'(instr[30:24]);
    assign dec_v = instr_v && (state == FETCH);

    always_comb begin
        dec_mac  = 1'b0;
        dec_clr  = 1'b0;
        dec_add  = 1'b0;
        dec_save = 1'b0;
        dec_halt = 1'b0;
        dec_bad  = 1'b0;
        if (dec_v) begin
            case (op)
                NOP:   ;
                MAC:   begin dec_mac = 1'b1; dec_add = 1'b1; end
                MACN:  dec_mac = 1'b1;
                MACZ:  begin dec_mac = 1'b1; dec_clr = 1'b1; dec_add = 1'b1; end
                MACNZ: begin dec_mac = 1'b1; dec_clr = 1'b1; end
                SAVE:  dec_save = 1'b1;
                HALT:  dec_halt = 1'b1;
                default: dec_bad = 1'b1;
            endcase
        end
    end

    // Control delay lines; the last add stage folds in the sample sign
    always_ff @(posedge ck) begin
        if (stop) begin
            en_sr   <= '0;
            clr_sr  <= '0;
            add_sr  <= '0;
            save_sr <= '0;
            halt_sr <= '0;
        end else begin
            en_sr   <= {en_sr[DLY-2:0], dec_mac};
            clr_sr  <= {clr_sr[DLY-2:0], dec_clr};
            save_sr <= {save_sr[DLY-2:0], dec_save};
            halt_sr <= {halt_sr[DLY-1:0], dec_halt};
            add_sr  <= {add_sr[DLY-2] ^ audio_neg, add_sr[DLY-3:0], dec_add};
        end
    end

    // Payload delay lines
    always_ff @(posedge ck) begin
        shift_sr[0] <= instr[23:20];
        gain_sr[0]  <= instr[15:0];
        idx_sr[0]   <= instr[3:0];     // Output index from gain's low bits
        for (int k = 1; k < DLY; k++)
            shift_sr[k] <= shift_sr[k-1];
        for (int k = 1; k < DLY - 1; k++)
            gain_sr[k] <= gain_sr[k-1];
        for (int k = 1; k <= DLY; k++)
            idx_sr[k] <= idx_sr[k-1];
    end

    assign acc_en   = en_sr[DLY-1];
    assign acc_clr  = clr_sr[DLY-1];
    assign acc_add  = add_sr[DLY-1];
    assign shift_en = save_sr[DLY-1];
    assign shift    = shift_sr[DLY-1];
    assign gain     = gain_sr[DLY-2];      // Meets the sample magnitude
    assign out_idx  = idx_sr[DLY];         // Lines up with out_we

    // Done follows the last possible output write
    always_ff @(posedge ck) begin
        if (stop) begin
            done  <= 1'b0;
            error <= 1'b0;
        end else begin
            if (halt_sr[DLY])
                done <= 1'b1;
            if (dec_bad)
                error <= 1'b1;
        end
    end

endmodule

// ==== source/mac_datapath.sv ====
// Sign-magnitude stage, 16x16 multiplier, 40-bit accumulator
// and the output shifter
`timescale 1ns/10ps
`include "mixer_cfg.svh"

module mac_datapath (
    input  logic               ck,
    input  logic               reset,
    input  mixer_pkg::sample_t audio_data,
    input  mixer_pkg::gain_t   gain,
    input  logic               acc_en,
    input  logic               acc_clr,
    input  logic               acc_add,
    input  logic               shift_en,
    input  mixer_pkg::frame_t  shift,
    output logic               audio_neg,
    output logic               out_we,
    output mixer_pkg::sample_t out_data
);
    import mixer_pkg::*;

    logic [15:0] mag;       // 0x8000 still fits unsigned
    product_t    product;
    acc_t        acc;
    acc_t        acc_base;
    acc_t        acc_next;
    acc_t        shifted;

    // Magnitude here, sign applied as subtract at the accumulator
    always_ff @(posedge ck) begin
        mag     <= audio_data[15] ? (~audio_data + 16'd1) : audio_data;
        product <= mag * gain;
    end

    always_ff @(posedge ck) begin
        if (reset)
            audio_neg <= 1'b0;
        else
            audio_neg <= audio_data[15];
    end

    assign acc_base = acc_clr ? '0 : acc;
    assign acc_next = acc_add ? acc_base + acc_t'(product)
                              : acc_base - acc_t'(product);

    always_ff @(posedge ck) begin
        if (reset)
            acc <= '0;
        else if (acc_en)
            acc <= acc_next;
    end

    // Keeps bits shift+15 down to shift
    assign shifted = acc >> shift;

    always_ff @(posedge ck) begin
        if (shift_en)
            out_data <= shifted[15:0];
    end

    always_ff @(posedge ck) begin
        if (reset)
            out_we <= 1'b0;
        else
            out_we <= shift_en;     // One cycle per SAVE
    end

endmodule

// ==== source/mixer_bus.sv ====
// Wishbone classic slave with the coefficient and audio RAMs,
// the output register file and the status word
`timescale 1ns/10ps
`include "mixer_cfg.svh"

module mixer_bus (
    input  logic                   ck,
    input  logic                   reset,
    input  logic                   wb_cyc,
    input  logic                   wb_stb,
    input  logic                   wb_we,
    input  logic [`MIX_WB_AW-1:0]  wb_adr,
    input  logic [31:0]            wb_dat_w,
    output logic [31:0]            wb_dat_r,
    output logic                   wb_ack,
    input  mixer_pkg::code_addr_t  coef_addr,
    output mixer_pkg::coef_word_t  coef_data,
    input  mixer_pkg::audio_addr_t audio_addr,
    output mixer_pkg::sample_t     audio_data,
    input  logic                   out_we,
    input  mixer_pkg::out_idx_t    out_idx,
    input  mixer_pkg::sample_t     out_data,
    input  logic                   done,
    input  logic                   error
);
    import mixer_pkg::*;

    localparam int AW  = `MIX_WB_AW;
    localparam int CW  = `MIX_CODE_W;
    localparam int SW  = `MIX_CHAN_W + `MIX_FRAME_W;
    localparam int OW  = $clog2(`MIX_OUT_N);
    localparam logic [AW-1:0] COEF_BASE   = `MIX_COEF_BASE;
    localparam logic [AW-1:0] AUDIO_BASE  = `MIX_AUDIO_BASE;
    localparam logic [AW-1:0] OUT_BASE    = `MIX_OUT_BASE;
    localparam logic [AW-1:0] STATUS_ADDR = `MIX_STATUS_ADDR;

    coef_word_t  coef_mem  [2**CW];
    sample_t     audio_mem [2**SW];
    sample_t     out_reg   [`MIX_OUT_N];
    logic        req;
    logic        hit_coef;
    logic        hit_audio;
    logic        hit_out;
    logic        hit_status;
    logic [31:0] rd_data;

    // New request only while no acknowledge is pending
    assign req = wb_cyc && wb_stb && !wb_ack;

    assign hit_coef   = (wb_adr[AW-1:CW] == COEF_BASE[AW-1:CW]);
    assign hit_audio  = (wb_adr[AW-1:SW] == AUDIO_BASE[AW-1:SW]);
    assign hit_out    = (wb_adr[AW-1:OW] == OUT_BASE[AW-1:OW]);
    assign hit_status = (wb_adr == STATUS_ADDR);

    always_comb begin
        rd_data = '0;                                   // Unmapped
        if (hit_coef)
            rd_data = coef_mem[wb_adr[CW-1:0]];
        else if (hit_audio)
            rd_data = {16'h0, audio_mem[wb_adr[SW-1:0]]};
        else if (hit_out)
            rd_data = {16'h0, out_reg[wb_adr[OW-1:0]]};
        else if (hit_status)
            rd_data = {30'h0, error, done};
    end

    always_ff @(posedge ck) begin
        if (reset)
            wb_ack <= 1'b0;
        else
            wb_ack <= req;
    end

    // Read data shows up with the acknowledge
    always_ff @(posedge ck) begin
        if (req && !wb_we)
            wb_dat_r <= rd_data;
    end

    // Coefficient RAM, bus write port and sequencer read port
    always_ff @(posedge ck) begin
        if (req && wb_we && hit_coef)
            coef_mem[wb_adr[CW-1:0]] <= wb_dat_w;
        coef_data <= coef_mem[coef_addr];
    end

    // Audio RAM, one 16-sample ring per channel
    always_ff @(posedge ck) begin
        if (req && wb_we && hit_audio)
            audio_mem[wb_adr[SW-1:0]] <= wb_dat_w[15:0];
        audio_data <= audio_mem[audio_addr];
    end

    always_ff @(posedge ck) begin
        if (out_we)
            out_reg[out_idx] <= out_data;
    end

endmodule

// ==== source/mixer_top.sv ====
// Mixing engine top level: sequencer, MAC datapath and bus block
`timescale 1ns/10ps
`include "mixer_cfg.svh"

module mixer_top (
    input  logic                  ck,
    input  logic                  reset,
    input  logic                  run,
    input  mixer_pkg::frame_t     frame,
    input  logic                  wb_cyc,
    input  logic                  wb_stb,
    input  logic                  wb_we,
    input  logic [`MIX_WB_AW-1:0] wb_adr,
    input  logic [31:0]           wb_dat_w,
    output logic [31:0]           wb_dat_r,
    output logic                  wb_ack,
    output logic                  done,
    output logic                  error
);
    import mixer_pkg::*;

    code_addr_t  coef_addr;
    coef_word_t  coef_data;
    audio_addr_t audio_addr;
    sample_t     audio_data;
    logic        acc_en;
    logic        acc_clr;
    logic        acc_add;
    logic        audio_neg;
    logic        shift_en;
    frame_t      shift;
    gain_t       gain;
    out_idx_t    out_idx;
    logic        out_we;
    sample_t     out_data;

    mix_sequencer seq (
        .ck, .reset, .run, .frame,
        .coef_addr, .coef_data, .audio_addr,
        .acc_en, .acc_clr, .acc_add, .audio_neg,
        .shift_en, .shift, .gain, .out_idx,
        .done, .error
    );

    mac_datapath dp (
        .ck, .reset, .audio_data, .gain,
        .acc_en, .acc_clr, .acc_add, .shift_en, .shift,
        .audio_neg, .out_we, .out_data
    );

    mixer_bus bus (
        .ck, .reset,
        .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w, .wb_dat_r, .wb_ack,
        .coef_addr, .coef_data, .audio_addr, .audio_data,
        .out_we, .out_idx, .out_data,
        .done, .error
    );

endmodule

// ==== dv/mixer_props.sv ====
// Concurrent checks on the Wishbone handshake, output writes
// and the done and error flags, bound into mixer_top
`timescale 1ns/10ps

module mixer_props (
    input logic ck,
    input logic reset,
    input logic run,
    input logic wb_cyc,
    input logic wb_stb,
    input logic wb_ack,
    input logic out_we,
    input logic done,
    input logic error
);

    int unsigned fail_cnt = 0;      // Read by mixer_tb

    ack_single: assert property (@(posedge ck) disable iff (reset) wb_ack |=> !wb_ack)
        else begin
            $error("wb_ack stayed high for a second cycle");
            fail_cnt++;
        end

    // Acknowledge only answers a strobe from the cycle before
    ack_after_stb: assert property (@(posedge ck) disable iff (reset)
        wb_ack |-> $past(wb_cyc && wb_stb))
        else begin
            $error("wb_ack raised without a preceding strobe");
            fail_cnt++;
        end

    out_we_single: assert property (@(posedge ck) disable iff (reset) out_we |=> !out_we)
        else begin
            $error("out_we high for two cycles");
            fail_cnt++;
        end

    flags_cleared: assert property (@(posedge ck) (reset || !run) |=> (!done && !error))
        else begin
            $error("done or error still set after reset or run low");
            fail_cnt++;
        end

    done_held: assert property (@(posedge ck) disable iff (reset)
        $fell(done) |-> $past(!run || reset))
        else begin
            $error("done fell while run stayed high");
            fail_cnt++;
        end

endmodule

bind mixer_top mixer_props props (
    .ck(ck),
    .reset(reset),
    .run(run),
    .wb_cyc(wb_cyc),
    .wb_stb(wb_stb),
    .wb_ack(wb_ack),
    .out_we(out_we),
    .done(done),
    .error(error)
);

// ==== dv/mixer_tb.sv ====
// Mixer testbench with clock, reset, Wishbone driver, program and audio loading,
// reference model and read-back checks
`timescale 1ns/10ps
`include "mixer_cfg.svh"

module mixer_tb;

    localparam logic [6:0] OP_NOP   = 7'h00;
    localparam logic [6:0] OP_MAC   = 7'h40;
    localparam logic [6:0] OP_MACN  = 7'h41;
    localparam logic [6:0] OP_MACZ  = 7'h42;
    localparam logic [6:0] OP_MACNZ = 7'h43;
    localparam logic [6:0] OP_SAVE  = 7'h50;
    localparam logic [6:0] OP_HALT  = 7'h7F;
    localparam logic [6:0] OP_BAD   = 7'h23;   // Not in the opcode table
    localparam int CYCLE_LIMIT = 20000;        // About 2000 cycles of bus traffic plus short runs

    logic        ck;
    logic        reset;
    logic        run;
    logic [3:0]  frame;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    logic [9:0]  wb_adr;
    logic [31:0] wb_dat_w;
    logic [31:0] wb_dat_r;
    logic        wb_ack;
    logic        done;
    logic        error;
    int          cycles = 0;

    // Reference copies of the RAMs, outputs and error flag
    logic [31:0] m_coef  [256];
    logic [15:0] m_audio [256];
    logic [15:0] m_out   [16];
    logic        m_known [16];
    logic        m_err;

    mixer_top UUT (
        .ck, .reset, .run, .frame,
        .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w, .wb_dat_r, .wb_ack,
        .done, .error
    );

    initial begin
        ck = 1'b0;
        forever #5 ck = ~ck;
    end

    always @(posedge ck) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT)
            stop_fail($sformatf("Timeout: no end of test after %0d cycles", cycles));
    end

    always @(negedge ck) begin
        if (UUT.props.fail_cnt != 0)
            stop_fail("A bound assertion on the DUT failed");
    end

    task automatic stop_fail(input string why);
        $display("%s", why);
        $display("Testbench failed");
        $fatal(1);
    endtask

    task automatic expect_word(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp)
        else stop_fail($sformatf("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp));
    endtask

    task automatic wait_ack;
        @(negedge ck);
        while (!wb_ack)
            @(negedge ck);
    endtask

    task automatic bus_write(input logic [9:0] adr, input logic [31:0] dat);
        @(negedge ck);
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = 1'b1;
        wb_adr   = adr;
        wb_dat_w = dat;
        wait_ack();
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
    endtask

    task automatic bus_read(input logic [9:0] adr, output logic [31:0] dat);
        @(negedge ck);
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        wb_we  = 1'b0;
        wb_adr = adr;
        wait_ack();
        dat    = wb_dat_r;      // Valid alongside the acknowledge
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
    endtask

    task automatic put_coef(input int pc, input logic [31:0] word);
        m_coef[pc] = word;
        bus_write(10'(`MIX_COEF_BASE + pc), word);
    endtask

    task automatic put_audio(input int a, input logic [15:0] s);
        m_audio[a] = s;
        bus_write(10'(`MIX_AUDIO_BASE + a), {16'h0, s});
    endtask

    task automatic put_instr(input int pc, input logic [6:0] op, input logic [3:0] off,
                             input logic [3:0] chan, input logic [15:0] gain);
        put_coef(pc, {1'b0, op, off, chan, gain});
    endtask

    // Runs the stored program on the reference copies
    task automatic run_model(input logic [3:0] frm);
        logic [39:0] acc;
        logic [39:0] prod;
        logic [39:0] scaled;
        logic [31:0] w;
        int          idx;
        acc   = '0;
        m_err = 1'b0;
        for (int pc = 0; pc < 256; pc++) begin
            w    = m_coef[pc];
            idx  = 16 * int'(w[19:16]) + (int'(frm) + int'(w[23:20])) % 16;  // Ring wrap
            prod = 40'(longint'(w[15:0]) * longint'($signed(m_audio[idx])));
            case (w[30:24])
                OP_NOP:   ;
                OP_MAC:   acc = acc + prod;
                OP_MACN:  acc = acc - prod;
                OP_MACZ:  acc = prod;
                OP_MACNZ: acc = -prod;
                OP_SAVE: begin
                    scaled          = acc >> w[23:20];
                    m_out[w[3:0]]   = scaled[15:0];
                    m_known[w[3:0]] = 1'b1;
                end
                OP_HALT:  break;
                default:  m_err = 1'b1;
            endcase
        end
    endtask

    task automatic check_status(input logic [1:0] exp);
        logic [31:0] got;
        bus_read(`MIX_STATUS_ADDR, got);
        expect_word("status", got, {30'h0, exp});
    endtask

    task automatic check_outputs;
        logic [31:0] got;
        for (int i = 0; i < 16; i++) begin
            if (m_known[i]) begin
                bus_read(10'(`MIX_OUT_BASE + i), got);
                expect_word($sformatf("out_reg[%0d]", i), got, {16'h0, m_out[i]});
            end
        end
    endtask

    task automatic run_program(input logic [3:0] frm);
        @(negedge ck);
        frame = frm;
        run   = 1'b1;
        while (!done)
            @(negedge ck);
        run_model(frm);
        expect_word("error", 32'(error), 32'(m_err));
        check_status({m_err, 1'b1});
        check_outputs();
    endtask

    task automatic stop_run;
        @(negedge ck);
        run = 1'b0;
        @(negedge ck);
        check_status(2'b00);
    endtask

    initial begin
        logic [31:0] got;
        logic [15:0] s;
        logic [9:0]  holes [3] = '{10'h211, 10'h2ff, 10'h3a5};
        reset    = 1'b1;
        run      = 1'b0;
        frame    = 4'd0;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = '0;
        wb_dat_w = '0;
        void'($urandom(32'h13d0_2aa6));
        for (int i = 0; i < 16; i++)
            m_known[i] = 1'b0;
        repeat (10) @(negedge ck);
        reset = 1'b0;

        // RAM write and read-back followed by unmapped holes
        for (int a = 240; a < 256; a++)
            put_coef(a, $urandom());
        for (int a = 0; a < 256; a++) begin
            s     = 16'($urandom());
            s[15] = a[0];       // Both signs in every ring
            put_audio(a, s);
        end
        for (int a = 240; a < 256; a++) begin
            bus_read(10'(`MIX_COEF_BASE + a), got);
            expect_word($sformatf("coef[%0d]", a), got, m_coef[a]);
        end
        for (int a = 0; a < 256; a++) begin
            bus_read(10'(`MIX_AUDIO_BASE + a), got);
            expect_word($sformatf("audio[%0d]", a), got, {16'h0, m_audio[a]});
        end
        foreach (holes[i]) begin
            bus_read(holes[i], got);
            expect_word($sformatf("wb_dat_r @ 0x%h", holes[i]), got, 32'h0);
        end

        // All four MAC kinds and saves with shifts 0, 4 and 8
        put_instr(0, OP_MACZ, 4'd1, 4'd2, 16'($urandom()));
        put_instr(1, OP_MAC, 4'd2, 4'd3, 16'($urandom()));
        put_instr(2, OP_MACN, 4'd0, 4'd4, 16'($urandom()));
        put_instr(3, OP_NOP, 4'd0, 4'd0, 16'h0);
        put_instr(4, OP_SAVE, 4'd0, 4'd0, 16'h0000);
        put_instr(5, OP_NOP, 4'd0, 4'd0, 16'h0);
        put_instr(6, OP_SAVE, 4'd4, 4'd0, 16'h0001);
        put_instr(7, OP_NOP, 4'd0, 4'd0, 16'h0);
        put_instr(8, OP_SAVE, 4'd8, 4'd0, 16'h0002);
        put_instr(9, OP_MACNZ, 4'd6, 4'd5, 16'($urandom()));
        put_instr(10, OP_MAC, 4'd9, 4'd6, 16'($urandom()));
        put_instr(11, OP_NOP, 4'd0, 4'd0, 16'h0);
        put_instr(12, OP_SAVE, 4'd4, 4'd0, 16'h0003);
        put_instr(13, OP_HALT, 4'd0, 4'd0, 16'h0);
        run_program(4'd5);
        stop_run();

        // Offsets past the end of the ring at two frame values
        put_instr(0, OP_MACZ, 4'd5, 4'd1, 16'($urandom()));
        put_instr(1, OP_MAC, 4'd15, 4'd1, 16'($urandom()));
        put_instr(2, OP_MACN, 4'd12, 4'd9, 16'($urandom()));
        put_instr(3, OP_NOP, 4'd0, 4'd0, 16'h0);
        put_instr(4, OP_SAVE, 4'd2, 4'd0, 16'h0004);
        put_instr(5, OP_MACNZ, 4'd9, 4'd8, 16'($urandom()));
        put_instr(6, OP_MACN, 4'd14, 4'd8, 16'($urandom()));
        put_instr(7, OP_NOP, 4'd0, 4'd0, 16'h0);
        put_instr(8, OP_SAVE, 4'd0, 4'd0, 16'h0005);
        put_instr(9, OP_HALT, 4'd0, 4'd0, 16'h0);
        run_program(4'd13);
        stop_run();
        run_program(4'd2);
        stop_run();

        // Unknown opcode sets error while later saves still land
        put_instr(0, OP_MACZ, 4'd0, 4'd10, 16'($urandom()));
        put_instr(1, OP_NOP, 4'd0, 4'd0, 16'h0);
        put_instr(2, OP_SAVE, 4'd1, 4'd0, 16'h0006);
        put_instr(3, OP_MAC, 4'd7, 4'd11, 16'($urandom()));
        put_instr(4, OP_BAD, 4'd0, 4'd0, 16'h0);
        put_instr(5, OP_SAVE, 4'd3, 4'd0, 16'h0007);
        put_instr(6, OP_HALT, 4'd0, 4'd0, 16'h0);
        run_program(4'd7);

        // Outputs hold after done and a rerun gives the same values
        repeat (20) @(negedge ck);
        check_outputs();
        stop_run();
        run_program(4'd12);     // Other frame changes out_reg[6] and out_reg[7]
        stop_run();
        run_program(4'd7);
        stop_run();

        if (UUT.props.fail_cnt == 0) begin
            $display("Testbench passed");
            $finish;
        end else begin
            stop_fail("Bound assertions reported failures");
        end
    end

endmodule

// ==== src.f ====
+incdir+source
source/mixer_pkg.sv
source/mix_sequencer.sv
source/mac_datapath.sv
source/mixer_bus.sv
source/mixer_top.sv
dv/mixer_props.sv
dv/mixer_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Compile the mixing engine with Verilator and run its testbench

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -j 0 \
    --top-module mixer_tb -f src.f -o mixer_sim > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "Verilator build failed, see build.log"
    exit 1
fi

# Assertion errors are counted by the testbench instead of aborting
./obj_dir/mixer_sim +verilator+error+limit+100 > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -qx "Testbench passed" sim.log; then
    exit 0
fi
echo "Pass message not found in sim.log"
exit 1
